//--- flist.f
hw/tcp_tx_pkg.sv
hw/tcp_tx_info_if.sv
hw/tcp_tx_job_if.sv
hw/tcp_tx_data_buf.sv
hw/tcp_tx_pkt_builder.sv
hw/tcp_tx_info_ram.sv
hw/tcp_tx_scanner.sv
hw/tcp_tx_streamer.sv
hw/tcp_tx_ctl.sv
dv/tcp_tx_ctl_tb.sv

//--- Makefile
TOP = tcp_tx_ctl_tb

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir -o $(TOP)
	obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@! grep -q "CHECKS FAILED" sim.log
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- dv/tcp_tx_ctl_tb.sv
`timescale 1ns/1ps

module tcp_tx_ctl_tb;

  localparam int RTX_TRIES = 3;
  localparam int PLD_MAX   = 32;    // mtu 112 less 80 header bytes
  localparam int TMO       = 3000;  // cycles allowed per wait
  localparam int QUIET     = 1200;  // longer than one retransmit period
  localparam int NROWS     = 5;
  localparam tcp_tx_pkg::seq_t ISS = 32'hffff_ffd0;  // seq wraps mid run

  logic              clk = 1'b0;
  logic              arst_n, init, connected;
  tcp_tx_pkg::seq_t  tcb_loc_seq, rem_ack;
  logic              in_val, in_snd, in_cts;
  tcp_tx_pkg::byte_t in_dat, strm_dat;
  tcp_tx_pkg::seq_t  loc_seq, pld_start, pld_stop, last_seq;
  tcp_tx_pkg::len_t  pld_lng;
  logic              tx_send, tx_req, tx_sent;
  logic              strm_val, strm_sof, strm_eof, force_dcn;

  // host side model
  tcp_tx_pkg::byte_t model [256];  // payload by low seq bits
  tcp_tx_pkg::seq_t  wr_seq;       // next seq the user writes
  tcp_tx_pkg::seq_t  exp_last;     // highest stop handed to the engine
  integer            seed = 19;
  int                err_val = 0;  // wrong values
  int                err_oth = 0;  // timeouts and protocol faults

  //////////////////////////////
  // stimulus table with one row per test

  string row_name [NROWS] = '{"snd_strobe", "idle_close", "mtu_split", "ack_free",
                              "rtx_timeout"};
  int    row_cnt  [NROWS] = '{10, 12, 40, 16, 20};       // bytes written
  bit    row_snd  [NROWS] = '{1, 0, 1, 1, 1};            // in_snd on the last byte
  bit    row_ack  [NROWS] = '{1, 1, 1, 1, 0};            // host acks each packet
  int    row_len0 [NROWS] = '{10, 12, PLD_MAX, 16, 20};  // expected first packet
  int    row_len1 [NROWS] = '{0, 0, 40 - PLD_MAX, 0, 0}; // second packet or 0 if none

  tcp_tx_ctl #(
    .MTU(112), .WAIT_TICKS(8), .RTX_TICKS(20), .RTX_TRIES(RTX_TRIES), .BUF_AW(8), .PKT_AW(3)
  ) dut_i (
    .clk, .arst_n, .init, .connected, .tcb_loc_seq, .rem_ack,
    .in_val, .in_dat, .in_snd, .in_cts, .loc_seq,
    .tx_send, .tx_req, .tx_sent, .strm_val, .strm_sof, .strm_eof, .strm_dat,
    .pld_start, .pld_stop, .pld_lng, .last_seq, .force_dcn
  );

  always #20 clk = ~clk;  // 40 ns period

  // inputs change and outputs are read 1 ns after the edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////
  // compare tasks

  task automatic check_seq(input string name, input tcp_tx_pkg::seq_t exp,
                           input tcp_tx_pkg::seq_t act);
    if (act !== exp) begin
      err_val++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_len(input string name, input tcp_tx_pkg::len_t exp,
                           input tcp_tx_pkg::len_t act);
    if (act !== exp) begin
      err_val++;
      $display("error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input tcp_tx_pkg::byte_t exp,
                            input tcp_tx_pkg::byte_t act);
    if (act !== exp) begin
      err_val++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_val++;
      $display("error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////
  // user and engine side

  // one random byte per cycle while in_cts allows and kept in the model
  task automatic write_bytes(input string name, input int cnt, input bit snd);
    int i;
    int n;
    for (i = 0; i < cnt; i++) begin
      n = 0;
      while (!in_cts && n < TMO) begin
        in_val = 1'b0;  // hold off until clear to send
        step();
        n++;
      end
      if (!in_cts) begin
        err_oth++;
        $display("timeout in %s: in_cts stayed low for %0d cycles", name, TMO);
        break;
      end
      in_val = 1'b1;
      in_dat = tcp_tx_pkg::byte_t'($random(seed));
      in_snd = snd && (i == cnt - 1);
      model[wr_seq[7:0]] = in_dat;
      wr_seq++;
      step();
    end
    in_val = 1'b0;
    in_snd = 1'b0;
    check_seq({name, " loc_seq"}, wr_seq, loc_seq);  // initial seq plus every byte
  endtask

  // engine waits for tx_send then requests, collects the bytes and reports sent
  task automatic serve_packet(input string name, input tcp_tx_pkg::seq_t start,
                              input tcp_tx_pkg::len_t lng);
    int               n;
    int               i;
    tcp_tx_pkg::seq_t stop;
    tcp_tx_pkg::seq_t s;
    stop = start + tcp_tx_pkg::seq_t'(lng);
    n = 0;
    while (!tx_send && n < TMO) begin
      step();
      n++;
    end
    if (!tx_send) begin
      err_oth++;
      $display("timeout in %s: no tx_send within %0d cycles", name, TMO);
      return;
    end
    check_bit({name, " force_dcn"}, 1'b0, force_dcn);  // retry limit not hit yet
    check_seq({name, " pld_start"}, start, pld_start);
    check_seq({name, " pld_stop"}, stop, pld_stop);
    check_len({name, " pld_lng"}, lng, pld_lng);
    repeat (3) step();  // engine latency
    tx_req = 1'b1;
    step();
    tx_req = 1'b0;
    s = start;
    for (i = 0; i < int'(lng); i++) begin  // one byte per cycle without back-pressure
      check_bit({name, " strm_val"}, 1'b1, strm_val);
      check_bit({name, " strm_sof"}, i == 0, strm_sof);
      check_bit({name, " strm_eof"}, i == int'(lng) - 1, strm_eof);
      check_byte({name, " strm_dat"}, model[s[7:0]], strm_dat);
      s++;
      step();
    end
    check_bit({name, " strm_val drop"}, 1'b0, strm_val);
    tx_sent = 1'b1;
    step();
    tx_sent = 1'b0;
    if ($signed(stop - exp_last) > 0) exp_last = stop;  // retransmits leave it alone
    check_seq({name, " last_seq"}, exp_last, last_seq);
  endtask

  //////////////////////////////
  // main sequence

  initial begin
    int               r;
    int               p;
    int               t;
    int               i;
    int               lng;
    int               nsend;
    tcp_tx_pkg::seq_t pkt_seq;
    arst_n      = 1'b0;
    init        = 1'b0;
    connected   = 1'b0;
    tcb_loc_seq = ISS;
    rem_ack     = ISS;
    in_val      = 1'b0;
    in_dat      = '0;
    in_snd      = 1'b0;
    tx_req      = 1'b0;
    tx_sent     = 1'b0;
    wr_seq      = ISS;
    exp_last    = ISS;

    repeat (2) @(posedge clk);  // two cycles in reset
    #1;
    check_bit("reset tx_send", 1'b0, tx_send);
    check_bit("reset strm_val", 1'b0, strm_val);
    check_bit("reset strm_sof", 1'b0, strm_sof);
    check_bit("reset strm_eof", 1'b0, strm_eof);
    check_bit("reset force_dcn", 1'b0, force_dcn);
    check_bit("reset in_cts", 1'b0, in_cts);
    arst_n = 1'b1;
    step();
    init = 1'b1;  // loads seq counters and the freed ack
    step();
    init = 1'b0;
    check_seq("init loc_seq", ISS, loc_seq);
    check_seq("init last_seq", ISS, last_seq);
    check_bit("init in_cts", 1'b0, in_cts);  // not connected yet
    connected = 1'b1;
    step();

    for (r = 0; r < NROWS; r++) begin
      pkt_seq = wr_seq;
      write_bytes(row_name[r], row_cnt[r], row_snd[r]);
      nsend = row_ack[r] ? 1 : RTX_TRIES;  // unacked comes back on each timeout
      for (p = 0; p < 2; p++) begin
        lng = (p == 0) ? row_len0[r] : row_len1[r];
        if (lng != 0) begin
          for (t = 0; t < nsend; t++) begin
            serve_packet(row_name[r], pkt_seq, tcp_tx_pkg::len_t'(lng));
          end
          if (row_ack[r]) rem_ack = pkt_seq + tcp_tx_pkg::seq_t'(lng);  // covers packet
          pkt_seq = pkt_seq + tcp_tx_pkg::seq_t'(lng);
        end
      end
    end

    // last row is never acked so the scanner gives up after RTX_TRIES sends
    i = 0;
    while (!force_dcn && i < TMO) begin
      step();
      i++;
    end
    if (!force_dcn) begin
      err_oth++;
      $display("timeout in rtx_timeout: force_dcn not raised within %0d cycles", TMO);
    end
    for (i = 0; i < QUIET; i++) begin
      if (tx_send) begin
        err_oth++;
        $display("rtx_timeout: a transmission started after force_dcn");
        break;
      end
      step();
    end
    check_bit("rtx_timeout force_dcn hold", 1'b1, force_dcn);

    $display("summary: %0d value errors, %0d other failures", err_val, err_oth);
    if (err_val == 0 && err_oth == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- hw/tcp_tx_ctl.sv
`timescale 1ns/1ps

module tcp_tx_ctl #(
  parameter int MTU        = 1500,
  parameter int WAIT_TICKS = 20,
  parameter int RTX_TICKS  = 1000,
  parameter int RTX_TRIES  = 5,
  parameter int BUF_AW     = 10,
  parameter int PKT_AW     = 3
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              init,
  input  logic              connected,
  input  tcp_tx_pkg::seq_t  tcb_loc_seq,
  input  tcp_tx_pkg::seq_t  rem_ack,
  // user byte stream
  input  logic              in_val,
  input  tcp_tx_pkg::byte_t in_dat,
  input  logic              in_snd,
  output logic              in_cts,
  output tcp_tx_pkg::seq_t  loc_seq,
  // engine side
  output logic              tx_send,
  input  logic              tx_req,
  input  logic              tx_sent,
  output logic              strm_val,
  output logic              strm_sof,
  output logic              strm_eof,
  output tcp_tx_pkg::byte_t strm_dat,
  output tcp_tx_pkg::seq_t  pld_start,
  output tcp_tx_pkg::seq_t  pld_stop,
  output tcp_tx_pkg::len_t  pld_lng,
  output tcp_tx_pkg::seq_t  last_seq,
  output logic              force_dcn
);

  logic             buf_full, tbl_full, add_pend;
  tcp_tx_pkg::seq_t freed_ack, rd_seq;
  logic [PKT_AW:0]  rem_ptr;

  tcp_tx_info_if #(.PKT_AW(PKT_AW)) info_if ();
  tcp_tx_job_if job_if ();

  assign in_cts    = connected && !tbl_full && !buf_full;
  assign pld_start = job_if.start;
  assign pld_stop  = job_if.stop;
  assign pld_lng   = job_if.lng;

  tcp_tx_data_buf #(.BUF_AW(BUF_AW)) data_buf_i (
    .clk, .arst_n, .wr(in_val), .wr_dat(in_dat), .wr_seq(loc_seq), .freed_ack,
    .rd_seq, .rd_dat(strm_dat), .full(buf_full)
  );

  tcp_tx_pkt_builder #(.MTU(MTU), .WAIT_TICKS(WAIT_TICKS), .PKT_AW(PKT_AW)) builder_i (
    .clk, .arst_n, .init, .tcb_loc_seq, .in_val, .in_snd, .buf_full, .loc_seq,
    .add_pend, .tbl_full, .info(info_if.builder), .rem_ptr
  );

  tcp_tx_info_ram #(.PKT_AW(PKT_AW)) info_ram_i (.clk, .info(info_if.ram));

  tcp_tx_scanner #(.RTX_TICKS(RTX_TICKS), .RTX_TRIES(RTX_TRIES), .PKT_AW(PKT_AW)) scanner_i (
    .clk, .arst_n, .init, .rem_ack, .add_pend, .freed_ack, .rem_ptr, .force_dcn,
    .info(info_if.scanner), .job(job_if.scanner)
  );

  tcp_tx_streamer streamer_i (
    .clk, .arst_n, .init, .tcb_loc_seq, .tx_send, .tx_req, .tx_sent,
    .strm_val, .strm_sof, .strm_eof, .rd_seq, .last_seq, .job(job_if.streamer)
  );

endmodule

//--- hw/tcp_tx_streamer.sv
`timescale 1ns/1ps

module tcp_tx_streamer (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             init,
  input  tcp_tx_pkg::seq_t tcb_loc_seq,
  output logic             tx_send,   // packet ready for the engine
  input  logic             tx_req,
  input  logic             tx_sent,
  output logic             strm_val,
  output logic             strm_sof,
  output logic             strm_eof,
  output tcp_tx_pkg::seq_t rd_seq,    // buffer read address
  output tcp_tx_pkg::seq_t last_seq,  // highest seq handed out
  tcp_tx_job_if.streamer   job
);

  tcp_tx_pkg::strm_state_t state;
  tcp_tx_pkg::len_t        cnt;    // index of byte on the bus, from 1
  tcp_tx_pkg::len_t        cnt_nxt;
  tcp_tx_pkg::seq_t        ahead;  // msb clear when stop is not behind last_seq

  assign cnt_nxt = cnt + 1'b1;
  assign ahead   = job.stop - last_seq;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= tcp_tx_pkg::strm_idle;
      {tx_send, strm_val, strm_sof, strm_eof} <= '0;
      {rd_seq, cnt, last_seq} <= '0;
      job.idle <= 1'b1;
    end else if (init) begin
      state <= tcp_tx_pkg::strm_idle;
      {tx_send, strm_val, strm_sof, strm_eof} <= '0;
      {rd_seq, cnt} <= '0;
      last_seq <= tcb_loc_seq;
      job.idle <= 1'b1;
    end else begin
      case (state)
        tcp_tx_pkg::strm_idle: begin
          if (job.send) begin
            tx_send  <= 1'b1;
            rd_seq   <= job.start;
            job.idle <= 1'b0;
            state    <= tcp_tx_pkg::strm_wait;
          end else job.idle <= 1'b1;  // one cycle after returning
        end
        tcp_tx_pkg::strm_wait: begin
          if (tx_req) begin  // first byte goes out next cycle
            tx_send  <= 1'b0;
            strm_val <= 1'b1;
            strm_sof <= 1'b1;
            strm_eof <= (job.lng == tcp_tx_pkg::len_t'(1));
            cnt      <= tcp_tx_pkg::len_t'(1);
            state    <= tcp_tx_pkg::strm_data;
          end
        end
        default: begin  // strm_data
          if (strm_eof) begin
            {strm_val, strm_sof, strm_eof} <= '0;
          end else if (strm_val) begin
            rd_seq   <= rd_seq + 1'b1;
            cnt      <= cnt_nxt;
            strm_sof <= 1'b0;
            strm_eof <= (cnt_nxt == job.lng);
          end
          if (tx_sent) begin
            if (!ahead[31] && ahead != '0) last_seq <= job.stop;  // retransmits keep it
            state <= tcp_tx_pkg::strm_idle;
          end
        end
      endcase
    end
  end

endmodule

//--- hw/tcp_tx_scanner.sv
`timescale 1ns/1ps

module tcp_tx_scanner #(
  parameter int RTX_TICKS = 1000,
  parameter int RTX_TRIES = 5,
  parameter int PKT_AW    = 3
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             init,
  input  tcp_tx_pkg::seq_t rem_ack,
  input  logic             add_pend,
  output tcp_tx_pkg::seq_t freed_ack,  // buffer may be reused below this
  output logic [PKT_AW:0]  rem_ptr,    // oldest live entry
  output logic             force_dcn,
  tcp_tx_info_if.scanner   info,
  tcp_tx_job_if.scanner    job
);

  tcp_tx_pkg::scan_state_t state;
  tcp_tx_pkg::pkt_rec_t    rec;       // entry being visited
  tcp_tx_pkg::seq_t        ack_dif;   // rem_ack - stop, msb set while unacked
  logic [PKT_AW-1:0]       upd_ptr;
  logic [PKT_AW-1:0]       next_ptr;  // next entry due for first transmission
  logic [PKT_AW:0]         tail;      // follows the builder's add pointer
  logic [PKT_AW:0]         fill;
  logic [PKT_AW-1:0]       ofs;
  logic add_q, live, valid, acked, do_free, do_tx, tx_first, tx_rtx;

  assign fill = tail - rem_ptr;
  assign ofs  = upd_ptr - rem_ptr[PKT_AW-1:0];

  assign tx_first = (rec.tries == '0) && (upd_ptr == next_ptr);  // in order only
  assign tx_rtx   = (rec.tries != '0) && (rec.rto == tcp_tx_pkg::rto_t'(RTX_TICKS)) &&
                    (rec.tries < tcp_tx_pkg::tries_t'(RTX_TRIES));

  assign info.upd_addr = upd_ptr;
  assign info.upd_rec  = rec;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= tcp_tx_pkg::scan_wait;
      {upd_ptr, next_ptr, rem_ptr, tail} <= '0;
      {add_q, live, valid, acked, do_free, do_tx} <= '0;
      force_dcn   <= 1'b0;
      freed_ack   <= '0;
      info.upd_wr <= 1'b0;
      job.send    <= 1'b0;
    end else if (init) begin
      state <= tcp_tx_pkg::scan_wait;
      {upd_ptr, next_ptr, rem_ptr, tail} <= '0;
      {add_q, live, valid, acked, do_free, do_tx} <= '0;
      force_dcn   <= 1'b0;
      freed_ack   <= rem_ack;  // nothing outstanding yet
      info.upd_wr <= 1'b0;
      job.send    <= 1'b0;
    end else begin
      add_q <= add_pend;
      if (add_q) tail <= tail + 1'b1;  // same edge the entry lands
      case (state)
        tcp_tx_pkg::scan_wait: begin
          live  <= ({1'b0, ofs} < fill);  // entry inside the written window
          state <= tcp_tx_pkg::scan_read;
        end
        tcp_tx_pkg::scan_read: state <= tcp_tx_pkg::scan_judge;
        tcp_tx_pkg::scan_judge: begin
          valid <= live && rec.exists;
          acked <= !ack_dif[31];
          state <= tcp_tx_pkg::scan_choose;
        end
        tcp_tx_pkg::scan_choose: begin
          do_free <= valid && acked && (upd_ptr == rem_ptr[PKT_AW-1:0]);  // oldest only
          do_tx   <= valid && !acked && job.idle && !force_dcn && (tx_first || tx_rtx);
          if (valid && !acked && rec.tries >= tcp_tx_pkg::tries_t'(RTX_TRIES))
            force_dcn <= 1'b1;  // give up on the connection
          if (!add_pend) state <= tcp_tx_pkg::scan_update;  // keep clear of port a
        end
        tcp_tx_pkg::scan_update: begin
          info.upd_wr <= valid;
          job.send    <= do_tx;
          if (do_free) begin
            freed_ack <= rec.stop;
            rem_ptr   <= rem_ptr + 1'b1;
          end
          if (do_tx && rec.tries == '0) next_ptr <= upd_ptr + 1'b1;
          state <= tcp_tx_pkg::scan_next;
        end
        default: begin  // scan_next, write lands and pointer moves on
          info.upd_wr <= 1'b0;
          job.send    <= 1'b0;
          upd_ptr     <= upd_ptr + 1'b1;
          state       <= tcp_tx_pkg::scan_wait;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == tcp_tx_pkg::scan_read) begin
      rec     <= info.upd_q;
      ack_dif <= rem_ack - info.upd_q.stop;
    end else if (state == tcp_tx_pkg::scan_update) begin
      if (do_free) rec.exists <= 1'b0;
      else if (do_tx) begin
        rec.tries <= rec.tries + 1'b1;
        rec.rto   <= '0;
        job.start <= rec.start;
        job.stop  <= rec.stop;
        job.lng   <= rec.length;
      end else if (rec.rto != tcp_tx_pkg::rto_t'(RTX_TICKS)) rec.rto <= rec.rto + 1'b1;
    end
  end

endmodule

//--- hw/tcp_tx_info_ram.sv
`timescale 1ns/1ps

module tcp_tx_info_ram #(
  parameter int PKT_AW = 3
) (
  input  logic       clk,
  tcp_tx_info_if.ram info
);

  tcp_tx_pkg::pkt_rec_t mem [2**PKT_AW];
  tcp_tx_pkg::pkt_rec_t q_b;

  //////////////////////////////
  // both ports write at the edge

  always_ff @(posedge clk) begin
    if (info.add_wr) mem[info.add_addr] <= info.add_rec;  // builder adds
    if (info.upd_wr) mem[info.upd_addr] <= info.upd_rec;  // scanner updates or frees
    q_b <= mem[info.upd_addr];                            // registered read, port b
  end

  assign info.upd_q = q_b;

endmodule

//--- hw/tcp_tx_pkt_builder.sv
`timescale 1ns/1ps

module tcp_tx_pkt_builder #(
  parameter int MTU        = 1500,
  parameter int WAIT_TICKS = 20,
  parameter int PKT_AW     = 3
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 init,
  input  tcp_tx_pkg::seq_t     tcb_loc_seq,
  input  logic                 in_val,
  input  logic                 in_snd,
  input  logic                 buf_full,
  output tcp_tx_pkg::seq_t     loc_seq,
  output logic                 add_pend,  // packet closes this cycle
  output logic                 tbl_full,
  tcp_tx_info_if.builder       info,
  input  logic [PKT_AW:0]      rem_ptr    // scanner's oldest entry
);

  localparam int PLD_MAX = MTU - tcp_tx_pkg::HDR_BYTES;
  localparam int IW      = $clog2(WAIT_TICKS + 1);

  tcp_tx_pkg::bld_state_t state;
  tcp_tx_pkg::seq_t       pkt_start;
  tcp_tx_pkg::len_t       cnt;
  tcp_tx_pkg::len_t       cnt_nxt;   // byte count including this cycle
  tcp_tx_pkg::pkt_rec_t   new_rec;
  logic [IW-1:0]          idle_ctr;  // idle cycles since last byte
  logic [PKT_AW:0]        add_ptr;
  logic [PKT_AW:0]        used;
  logic                   pend;
  logic                   add_wr;

  assign pend    = (state == tcp_tx_pkg::bld_pend);
  assign cnt_nxt = (pend ? cnt : '0) + tcp_tx_pkg::len_t'(in_val);

  // close on send strobe, payload limit, full buffer or idle gap
  assign add_pend = (pend || in_val) &&
                    ((in_val && in_snd) || cnt_nxt == tcp_tx_pkg::len_t'(PLD_MAX) ||
                     buf_full || (pend && !in_val && idle_ctr == IW'(WAIT_TICKS - 1)));

  // one slot stays free for the packet still being built
  assign used     = add_ptr - rem_ptr + (PKT_AW + 1)'(add_wr);
  assign tbl_full = (used >= (PKT_AW + 1)'(2**PKT_AW - 1));

  assign info.add_addr = add_ptr[PKT_AW-1:0];
  assign info.add_rec  = new_rec;
  assign info.add_wr   = add_wr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= tcp_tx_pkg::bld_idle;
      loc_seq  <= '0;
      cnt      <= '0;
      idle_ctr <= '0;
      add_ptr  <= '0;
      add_wr   <= 1'b0;
    end else if (init) begin
      state    <= tcp_tx_pkg::bld_idle;
      loc_seq  <= tcb_loc_seq;  // connection's initial seq
      cnt      <= '0;
      idle_ctr <= '0;
      add_ptr  <= '0;
      add_wr   <= 1'b0;
    end else begin
      if (in_val) loc_seq <= loc_seq + 1'b1;
      add_wr <= add_pend;                      // table write one cycle after close
      if (add_wr) add_ptr <= add_ptr + 1'b1;
      if (add_pend)    state <= tcp_tx_pkg::bld_idle;
      else if (in_val) state <= tcp_tx_pkg::bld_pend;
      cnt <= cnt_nxt;
      if (in_val || !pend) idle_ctr <= '0;
      else                 idle_ctr <= idle_ctr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!pend && in_val) pkt_start <= loc_seq;  // first byte of a new packet
    if (add_pend) begin
      new_rec.start  <= pend ? pkt_start : loc_seq;
      new_rec.stop   <= loc_seq + tcp_tx_pkg::seq_t'(in_val);  // expected ack
      new_rec.length <= cnt_nxt;
      new_rec.tries  <= '0;  // never sent
      new_rec.rto    <= '0;
      new_rec.exists <= 1'b1;
    end
  end

endmodule

//--- hw/tcp_tx_data_buf.sv
`timescale 1ns/1ps

module tcp_tx_data_buf #(
  parameter int BUF_AW = 10
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              wr,
  input  tcp_tx_pkg::byte_t wr_dat,
  input  tcp_tx_pkg::seq_t  wr_seq,     // local seq of the byte being written
  input  tcp_tx_pkg::seq_t  freed_ack,  // everything below is released
  input  tcp_tx_pkg::seq_t  rd_seq,
  output tcp_tx_pkg::byte_t rd_dat,
  output logic              full
);

  localparam int DEPTH = 2**BUF_AW;

  tcp_tx_pkg::byte_t mem [DEPTH];
  tcp_tx_pkg::seq_t  fill;  // bytes held after this cycle's write

  // freed_ack moving in the same cycle only makes full pessimistic
  assign fill = wr_seq + tcp_tx_pkg::seq_t'(wr) - freed_ack;

  always_ff @(posedge clk) begin
    if (wr) mem[wr_seq[BUF_AW-1:0]] <= wr_dat;  // low seq bits address the ring
  end

  assign rd_dat = mem[rd_seq[BUF_AW-1:0]];  // async read, byte shows with its address

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) full <= 1'b0;
    else         full <= (fill >= tcp_tx_pkg::seq_t'(DEPTH - 1));  // one slot kept spare
  end

endmodule

//--- hw/tcp_tx_job_if.sv
`timescale 1ns/1ps

interface tcp_tx_job_if;

  logic             send;   // one cycle, only while idle
  tcp_tx_pkg::seq_t start;  // held until next send
  tcp_tx_pkg::seq_t stop;
  tcp_tx_pkg::len_t lng;
  logic             idle;   // streamer free for a new packet

  modport scanner (
    output send, start, stop, lng,
    input  idle
  );

  modport streamer (
    input  send, start, stop, lng,
    output idle
  );

endinterface

//--- hw/tcp_tx_info_if.sv
`timescale 1ns/1ps

interface tcp_tx_info_if #(
  parameter int PKT_AW = 3
);

  // port a, new packets from the builder
  logic [PKT_AW-1:0]    add_addr;
  tcp_tx_pkg::pkt_rec_t add_rec;
  logic                 add_wr;

  // port b, scan and update
  logic [PKT_AW-1:0]    upd_addr;
  tcp_tx_pkg::pkt_rec_t upd_rec;
  logic                 upd_wr;
  tcp_tx_pkg::pkt_rec_t upd_q;     // entry at upd_addr, one cycle late

  modport builder (output add_addr, add_rec, add_wr);
  modport scanner (output upd_addr, upd_rec, upd_wr, input upd_q);
  modport ram (
    input  add_addr, add_rec, add_wr, upd_addr, upd_rec, upd_wr,
    output upd_q
  );

endinterface

//--- hw/tcp_tx_pkg.sv
package tcp_tx_pkg;

  //////////////////////////////
  // widths

  typedef logic [31:0] seq_t;    // tcp seq/ack, compared by sign of difference
  typedef logic [7:0]  byte_t;   // payload byte
  typedef logic [15:0] len_t;    // payload length of one packet
  typedef logic [3:0]  tries_t;  // transmission attempts
  typedef logic [23:0] rto_t;    // timeout in scan visits

  // one packet table entry
  typedef struct packed {
    seq_t   start;   // first seq of the packet
    seq_t   stop;    // seq after last byte, the ack that covers it
    len_t   length;
    tries_t tries;
    rto_t   rto;
    logic   exists;
  } pkt_rec_t;

  localparam int HDR_BYTES = 80;  // ipv4 + tcp header incl. options

  //////////////////////////////
  // fsm encodings

  typedef enum logic {bld_idle, bld_pend} bld_state_t;

  typedef enum logic [2:0] {
    scan_read, scan_judge, scan_choose, scan_update, scan_next, scan_wait
  } scan_state_t;

  typedef enum logic [1:0] {strm_idle, strm_wait, strm_data} strm_state_t;

endpackage
